// File: ant_pkg.sv
package ant_pkg;

    localparam int ANT_ID_WIDTH = 6;

    typedef logic [ANT_ID_WIDTH-1:0] ant_id_t;

    // Which of the three words of an ant is addressed
    typedef enum logic [1:0] {
        FIELD_X       = 2'd0,
        FIELD_Y       = 2'd1,
        FIELD_FITNESS = 2'd2
    } ant_field_t;

    // Ant id in the upper bits, field code in the lower two
    typedef logic [ANT_ID_WIDTH+1:0] mem_addr_t;

    typedef logic [7:0]  x_coord_t;
    typedef logic [6:0]  y_coord_t;
    typedef logic [2:0]  colour_t;
    typedef logic [15:0] word_t;

    typedef enum logic [1:0] {
        OPCODE_MEMREAD  = 2'd0,
        OPCODE_MEMWRITE = 2'd1,
        OPCODE_DRAW     = 2'd2
    } opcode_t;

    // Red
    localparam colour_t COLOUR_ANT = 3'b100;

    typedef enum logic {
        MODE_UPDATE = 1'b0,
        MODE_DRAW   = 1'b1
    } job_mode_t;

    typedef struct packed {
        logic left;
        logic right;
        logic up;
        logic down;
    } move_req_t;

    typedef struct packed {
        ant_id_t   id;
        job_mode_t mode;
        move_req_t move;
    } ant_job_t;

    typedef struct packed {
        word_t     data;
        mem_addr_t addr;
        opcode_t   opcode;
    } mem_instr_t;

    typedef struct packed {
        logic [4:0] pad;
        logic       plot;
        colour_t    colour;
        y_coord_t   y;
        x_coord_t   x;
        opcode_t    opcode;
    } draw_instr_t;

    // Opcode sits in the low two bits of both views
    typedef union packed {
        mem_instr_t  mem;
        draw_instr_t draw;
    } ant_instr_u;

    function automatic mem_addr_t ant_addr(ant_id_t id, ant_field_t field);
        return {id, field};
    endfunction

endpackage

// File: ant_job_latch.sv
module ant_job_latch (
    input  logic              clock,
    input  logic              resetn,
    input  logic              start,
    input  ant_pkg::ant_job_t job,
    input  logic              job_done,
    output logic              go,
    output ant_pkg::ant_job_t held_job,
    output logic              finished
);

    // Finished doubles as the idle flag
    always_ff @(posedge clock) begin
        if (!resetn) begin
            finished <= 1'b1;
            go       <= 1'b0;
        end else begin
            go <= 1'b0;
            if (start && finished) begin
                finished <= 1'b0;
                go       <= 1'b1;
            end else if (job_done) begin
                finished <= 1'b1;
            end
        end
    end

    // Job word is only sampled when a new job is accepted
    always_ff @(posedge clock) begin
        if (start && finished) begin
            held_job <= job;
        end
    end

    // A job can only complete while one is running
    done_while_busy: assert property (
        @(posedge clock) disable iff (!resetn)
        job_done |-> !finished
    );

endmodule

// File: ant_sequencer.sv
module ant_sequencer #(
    parameter int ANT_WIDTH     = 4,
    parameter int ANT_HEIGHT    = 4,
    parameter int SCREEN_WIDTH  = 160,
    parameter int SCREEN_HEIGHT = 120
) (
    input  logic                clock,
    input  logic                resetn,
    input  logic                go,
    input  ant_pkg::ant_job_t   held_job,
    output logic                job_done,
    output logic                req,
    output ant_pkg::ant_instr_u instr,
    input  logic                done,
    input  ant_pkg::word_t      result
);

    // Margins that keep the sprite on screen
    localparam ant_pkg::x_coord_t X_MIN = ant_pkg::x_coord_t'(ANT_WIDTH / 2);
    localparam ant_pkg::x_coord_t X_MAX = ant_pkg::x_coord_t'(SCREEN_WIDTH - ANT_WIDTH / 2 - 1);
    localparam ant_pkg::y_coord_t Y_MIN = ant_pkg::y_coord_t'(ANT_HEIGHT / 2);
    localparam ant_pkg::y_coord_t Y_MAX = ant_pkg::y_coord_t'(SCREEN_HEIGHT - ANT_HEIGHT / 2 - 1);
    localparam ant_pkg::x_coord_t DX_LAST = ant_pkg::x_coord_t'(ANT_WIDTH - 1);
    localparam ant_pkg::y_coord_t DY_LAST = ant_pkg::y_coord_t'(ANT_HEIGHT - 1);

    typedef enum logic [3:0] {
        ST_IDLE,
        ST_LOAD_X,
        ST_LOAD_Y,
        ST_LOAD_FIT,
        ST_MOVE,
        ST_STORE_X,
        ST_STORE_Y,
        ST_STORE_FIT,
        ST_DRAW
    } seq_state_t;

    seq_state_t        state;
    logic              pending;
    logic              draw_mode;
    logic              last_pixel;
    ant_pkg::x_coord_t x;
    ant_pkg::y_coord_t y;
    ant_pkg::word_t    fitness;
    ant_pkg::x_coord_t dx;
    ant_pkg::y_coord_t dy;
    ant_pkg::x_coord_t x_moved;
    ant_pkg::y_coord_t y_moved;

    assign draw_mode  = (held_job.mode == ant_pkg::MODE_DRAW);
    assign last_pixel = (dx == DX_LAST) && (dy == DY_LAST);

    // Every state except idle and move owns one transaction
    assign req = (state != ST_IDLE) && (state != ST_MOVE) && !pending;

    // Move rules apply in order, each on the result of the one before
    always_comb begin
        x_moved = x;
        y_moved = y;
        if (held_job.move.left && x_moved > X_MIN) begin
            x_moved = x_moved - 1'b1;
        end
        if (held_job.move.right && x_moved < X_MAX) begin
            x_moved = x_moved + 1'b1;
        end
        if (held_job.move.up && y_moved > Y_MIN) begin
            y_moved = y_moved - 1'b1;
        end
        if (held_job.move.down && y_moved < Y_MAX) begin
            y_moved = y_moved + 1'b1;
        end
    end

    always_comb begin
        instr = '0;
        case (state)
            ST_LOAD_X: begin
                instr.mem.addr   = ant_pkg::ant_addr(held_job.id, ant_pkg::FIELD_X);
                instr.mem.opcode = ant_pkg::OPCODE_MEMREAD;
            end
            ST_LOAD_Y: begin
                instr.mem.addr   = ant_pkg::ant_addr(held_job.id, ant_pkg::FIELD_Y);
                instr.mem.opcode = ant_pkg::OPCODE_MEMREAD;
            end
            ST_LOAD_FIT: begin
                instr.mem.addr   = ant_pkg::ant_addr(held_job.id, ant_pkg::FIELD_FITNESS);
                instr.mem.opcode = ant_pkg::OPCODE_MEMREAD;
            end
            ST_STORE_X: begin
                instr.mem.data   = ant_pkg::word_t'(x);
                instr.mem.addr   = ant_pkg::ant_addr(held_job.id, ant_pkg::FIELD_X);
                instr.mem.opcode = ant_pkg::OPCODE_MEMWRITE;
            end
            ST_STORE_Y: begin
                instr.mem.data   = ant_pkg::word_t'(y);
                instr.mem.addr   = ant_pkg::ant_addr(held_job.id, ant_pkg::FIELD_Y);
                instr.mem.opcode = ant_pkg::OPCODE_MEMWRITE;
            end
            ST_STORE_FIT: begin
                instr.mem.data   = fitness;
                instr.mem.addr   = ant_pkg::ant_addr(held_job.id, ant_pkg::FIELD_FITNESS);
                instr.mem.opcode = ant_pkg::OPCODE_MEMWRITE;
            end
            ST_DRAW: begin
                instr.draw.plot   = 1'b1;
                instr.draw.colour = ant_pkg::COLOUR_ANT;
                instr.draw.y      = y + dy;
                instr.draw.x      = x + dx;
                instr.draw.opcode = ant_pkg::OPCODE_DRAW;
            end
            default: begin
                instr = '0;
            end
        endcase
    end

    always_ff @(posedge clock) begin
        if (!resetn) begin
            state    <= ST_IDLE;
            pending  <= 1'b0;
            job_done <= 1'b0;
        end else begin
            job_done <= 1'b0;
            if (req) begin
                pending <= 1'b1;
            end else if (done) begin
                pending <= 1'b0;
            end
            case (state)
                ST_IDLE:  if (go) state <= ST_LOAD_X;
                ST_MOVE:  state <= ST_STORE_X;
                default: begin
                    if (done) begin
                        case (state)
                            ST_LOAD_X:   state <= ST_LOAD_Y;
                            ST_LOAD_Y:   state <= draw_mode ? ST_DRAW : ST_LOAD_FIT;
                            ST_LOAD_FIT: state <= ST_MOVE;
                            ST_STORE_X:  state <= ST_STORE_Y;
                            ST_STORE_Y:  state <= ST_STORE_FIT;
                            default: begin
                                // Last store, or draw with the final pixel
                                if (state == ST_STORE_FIT || last_pixel) begin
                                    state    <= ST_IDLE;
                                    job_done <= 1'b1;
                                end
                            end
                        endcase
                    end
                end
            endcase
        end
    end

    // Ant words and sprite offsets
    always_ff @(posedge clock) begin
        if (go) begin
            dx <= '0;
            dy <= '0;
        end
        if (state == ST_MOVE) begin
            x <= x_moved;
            y <= y_moved;
        end
        if (done) begin
            case (state)
                // Draw origin sits one pixel up and left of the ant position
                ST_LOAD_X:   x <= ant_pkg::x_coord_t'(result) - (draw_mode ? 1'b1 : 1'b0);
                ST_LOAD_Y:   y <= ant_pkg::y_coord_t'(result) - (draw_mode ? 1'b1 : 1'b0);
                ST_LOAD_FIT: fitness <= result;
                ST_DRAW: begin
                    if (dx == DX_LAST) begin
                        dx <= '0;
                        dy <= dy + 1'b1;
                    end else begin
                        dx <= dx + 1'b1;
                    end
                end
                default: begin
                end
            endcase
        end
    end

    // An answer only arrives for a request that is still open
    answer_for_open_req: assert property (
        @(posedge clock) disable iff (!resetn)
        done |-> pending
    );

    offsets_in_sprite: assert property (
        @(posedge clock) disable iff (!resetn)
        (state == ST_DRAW) |-> (int'(dx) < ANT_WIDTH) && (int'(dy) < ANT_HEIGHT)
    );

endmodule

// File: dp_transaction.sv
module dp_transaction (
    input  logic                clock,
    input  logic                resetn,
    input  logic                req,
    input  ant_pkg::ant_instr_u instr,
    output logic                done,
    output ant_pkg::word_t      result,
    output logic                start_dp,
    output ant_pkg::ant_instr_u instruction_dp,
    input  logic                finished_dp,
    input  ant_pkg::word_t      result_dp
);

    typedef enum logic [1:0] {
        ST_STROBE,
        ST_STROBE2,
        ST_WAIT
    } dp_state_t;

    dp_state_t state;
    // High from the request until the datapath has answered
    logic      busy;

    always_ff @(posedge clock) begin
        if (!resetn) begin
            state    <= ST_WAIT;
            busy     <= 1'b0;
            start_dp <= 1'b0;
            done     <= 1'b0;
        end else begin
            done <= 1'b0;
            case (state)
                ST_STROBE: begin
                    state <= ST_STROBE2;
                end
                ST_STROBE2: begin
                    start_dp <= 1'b0;
                    state    <= ST_WAIT;
                end
                default: begin
                    if (busy && finished_dp) begin
                        busy <= 1'b0;
                        done <= 1'b1;
                    end else if (!busy && req) begin
                        busy     <= 1'b1;
                        start_dp <= 1'b1;
                        state    <= ST_STROBE;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (state == ST_WAIT && !busy && req) begin
            instruction_dp <= instr;
        end
        if (state == ST_WAIT && busy && finished_dp) begin
            result <= result_dp;
        end
    end

    // A request is only taken while no transaction is open
    req_only_when_idle: assert property (
        @(posedge clock) disable iff (!resetn)
        req |-> (state == ST_WAIT) && !busy
    );

    // Datapath must not answer before the strobe has ended
    no_early_finish: assert property (
        @(posedge clock) disable iff (!resetn)
        start_dp |-> !finished_dp
    );

endmodule

// File: ant_engine.sv
module ant_engine #(
    parameter int ANT_WIDTH     = 4,
    parameter int ANT_HEIGHT    = 4,
    parameter int SCREEN_WIDTH  = 160,
    parameter int SCREEN_HEIGHT = 120
) (
    input  logic                clock,
    input  logic                resetn,
    input  logic                start,
    input  ant_pkg::ant_job_t   job,
    output logic                finished,
    output logic                start_dp,
    output ant_pkg::ant_instr_u instruction_dp,
    input  logic                finished_dp,
    input  ant_pkg::word_t      result_dp
);

    logic                go;
    logic                job_done;
    ant_pkg::ant_job_t   held_job;
    logic                req;
    logic                done;
    ant_pkg::ant_instr_u instr;
    ant_pkg::word_t      result;

    ant_job_latch ant_job_latch_inst (
        .clock    (clock),
        .resetn   (resetn),
        .start    (start),
        .job      (job),
        .job_done (job_done),
        .go       (go),
        .held_job (held_job),
        .finished (finished)
    );

    ant_sequencer #(
        .ANT_WIDTH     (ANT_WIDTH),
        .ANT_HEIGHT    (ANT_HEIGHT),
        .SCREEN_WIDTH  (SCREEN_WIDTH),
        .SCREEN_HEIGHT (SCREEN_HEIGHT)
    ) ant_sequencer_inst (
        .clock    (clock),
        .resetn   (resetn),
        .go       (go),
        .held_job (held_job),
        .job_done (job_done),
        .req      (req),
        .instr    (instr),
        .done     (done),
        .result   (result)
    );

    dp_transaction dp_transaction_inst (
        .clock          (clock),
        .resetn         (resetn),
        .req            (req),
        .instr          (instr),
        .done           (done),
        .result         (result),
        .start_dp       (start_dp),
        .instruction_dp (instruction_dp),
        .finished_dp    (finished_dp),
        .result_dp      (result_dp)
    );

endmodule

// File: tb_dp_model.sv
module tb_dp_model (
    input  logic                clock,
    input  logic                start_dp,
    input  ant_pkg::ant_instr_u instruction_dp,
    output logic                finished_dp,
    output ant_pkg::word_t      result_dp
);

    localparam int MEM_WORDS = 1 << (ant_pkg::ANT_ID_WIDTH + 2);

    // Ant words, filled by the testbench before the first job
    ant_pkg::word_t      mem [0:MEM_WORDS-1];
    // Every draw command seen, in arrival order
    ant_pkg::ant_instr_u draw_log [$];
    int                  bad_cmds;

    initial begin : serve_commands
        ant_pkg::ant_instr_u cmd;
        int                  delay;
        finished_dp = 1'b0;
        result_dp   = '0;
        bad_cmds    = 0;
        forever begin
            @(posedge clock);
            #1;
            if (start_dp) begin
                cmd = instruction_dp;
                // Let the two-cycle strobe run out
                while (start_dp) begin
                    @(posedge clock);
                    #1;
                end
                delay = $urandom_range(5, 1);
                repeat (delay - 1) begin
                    @(posedge clock);
                    #1;
                end
                result_dp = '0;
                case (cmd.mem.opcode)
                    ant_pkg::OPCODE_MEMREAD:  result_dp = mem[cmd.mem.addr];
                    ant_pkg::OPCODE_MEMWRITE: mem[cmd.mem.addr] = cmd.mem.data;
                    ant_pkg::OPCODE_DRAW:     draw_log.push_back(cmd);
                    default: begin
                        bad_cmds++;
                        $display("Datapath model received an unknown opcode in %h", cmd);
                    end
                endcase
                finished_dp = 1'b1;
                @(posedge clock);
                #1;
                finished_dp = 1'b0;
            end
        end
    end

endmodule

// File: tb_ant_engine.sv
module tb_ant_engine;

    localparam int ANT_WIDTH      = 4;
    localparam int ANT_HEIGHT     = 4;
    localparam int SCREEN_WIDTH   = 160;
    localparam int SCREEN_HEIGHT  = 120;
    localparam int X_MIN          = ANT_WIDTH / 2;
    localparam int X_MAX          = SCREEN_WIDTH - ANT_WIDTH / 2 - 1;
    localparam int Y_MIN          = ANT_HEIGHT / 2;
    localparam int Y_MAX          = SCREEN_HEIGHT - ANT_HEIGHT / 2 - 1;
    localparam int MEM_WORDS      = 1 << (ant_pkg::ANT_ID_WIDTH + 2);
    localparam int NUM_JOBS       = 17;
    localparam int TIMEOUT_CYCLES = 400 * NUM_JOBS;

    logic                clock;
    logic                resetn;
    logic                start;
    ant_pkg::ant_job_t   job;
    logic                finished;
    logic                start_dp;
    ant_pkg::ant_instr_u instruction_dp;
    logic                finished_dp;
    ant_pkg::word_t      result_dp;

    ant_pkg::word_t      exp_mem [0:MEM_WORDS-1];
    ant_pkg::ant_instr_u exp_draw [$];
    string               test_name;
    int                  jobs_issued;
    int                  jobs_checked;
    int                  draw_seen;
    int                  checks;
    int                  errors;

    ant_engine #(
        .ANT_WIDTH     (ANT_WIDTH),
        .ANT_HEIGHT    (ANT_HEIGHT),
        .SCREEN_WIDTH  (SCREEN_WIDTH),
        .SCREEN_HEIGHT (SCREEN_HEIGHT)
    ) ant_engine_inst (
        .clock          (clock),
        .resetn         (resetn),
        .start          (start),
        .job            (job),
        .finished       (finished),
        .start_dp       (start_dp),
        .instruction_dp (instruction_dp),
        .finished_dp    (finished_dp),
        .result_dp      (result_dp)
    );

    tb_dp_model dp_model_inst (
        .clock          (clock),
        .start_dp       (start_dp),
        .instruction_dp (instruction_dp),
        .finished_dp    (finished_dp),
        .result_dp      (result_dp)
    );

    initial begin
        clock = 1'b0;
        forever #20 clock = ~clock;
    end

    // One step towards each requested side, blocked at the margin
    function automatic ant_pkg::word_t moved_coord(ant_pkg::word_t pos, logic dec, logic inc,
                                                   int lo, int hi);
        int p;
        p = int'(pos);
        if (dec && p > lo) begin
            p = p - 1;
        end
        if (inc && p < hi) begin
            p = p + 1;
        end
        return ant_pkg::word_t'(p);
    endfunction

    // Sprite pixels in raster order from the origin up and left of the ant
    function automatic void queue_draw_pixels(ant_pkg::word_t x_word, ant_pkg::word_t y_word);
        ant_pkg::ant_instr_u pixel;
        for (int dy = 0; dy < ANT_HEIGHT; dy++) begin
            for (int dx = 0; dx < ANT_WIDTH; dx++) begin
                pixel             = '0;
                pixel.draw.plot   = 1'b1;
                pixel.draw.colour = ant_pkg::COLOUR_ANT;
                pixel.draw.x      = ant_pkg::x_coord_t'(int'(x_word) - 1 + dx);
                pixel.draw.y      = ant_pkg::y_coord_t'(int'(y_word) - 1 + dy);
                pixel.draw.opcode = ant_pkg::OPCODE_DRAW;
                exp_draw.push_back(pixel);
            end
        end
    endfunction

    function automatic ant_pkg::ant_job_t make_job(int id, ant_pkg::job_mode_t mode,
                                                   logic [3:0] move);
        ant_pkg::ant_job_t j;
        j.id   = ant_pkg::ant_id_t'(id);
        j.mode = mode;
        j.move = ant_pkg::move_req_t'(move);
        return j;
    endfunction

    task automatic check_word(string name, ant_pkg::word_t expected, ant_pkg::word_t actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("ERROR %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    task automatic check_instr(string name, ant_pkg::ant_instr_u expected,
                               ant_pkg::ant_instr_u actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("ERROR %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    task automatic check_count(string name, int expected, int actual);
        checks++;
        if (actual != expected) begin
            errors++;
            $display("ERROR %s draw count: expected %0d, actual %0d", name, expected, actual);
        end
    endtask

    // Writes a position both into the datapath memory and the expected copy
    task automatic place_ant(int id, int x, int y);
        ant_pkg::mem_addr_t ax;
        ant_pkg::mem_addr_t ay;
        ax = {ant_pkg::ant_id_t'(id), ant_pkg::FIELD_X};
        ay = {ant_pkg::ant_id_t'(id), ant_pkg::FIELD_Y};
        exp_mem[ax] = ant_pkg::word_t'(x);
        exp_mem[ay] = ant_pkg::word_t'(y);
        dp_model_inst.mem[ax] = ant_pkg::word_t'(x);
        dp_model_inst.mem[ay] = ant_pkg::word_t'(y);
    endtask

    task automatic launch_job(string name, ant_pkg::ant_job_t j);
        ant_pkg::mem_addr_t ax;
        ant_pkg::mem_addr_t ay;
        ax = {j.id, ant_pkg::FIELD_X};
        ay = {j.id, ant_pkg::FIELD_Y};
        test_name = name;
        if (j.mode == ant_pkg::MODE_UPDATE) begin
            exp_mem[ax] = moved_coord(exp_mem[ax], j.move.left, j.move.right, X_MIN, X_MAX);
            exp_mem[ay] = moved_coord(exp_mem[ay], j.move.up, j.move.down, Y_MIN, Y_MAX);
        end else begin
            queue_draw_pixels(exp_mem[ax], exp_mem[ay]);
        end
        jobs_issued++;
        @(posedge clock);
        #1;
        start = 1'b1;
        job   = j;
        @(posedge clock);
        #1;
        start = 1'b0;
    endtask

    task automatic wait_job_checked();
        wait (jobs_checked == jobs_issued);
    endtask

    // Compares memory and draw log each time a job completes
    initial begin : compare_results
        logic finished_prev;
        int   n;
        finished_prev = 1'b1;
        forever begin
            @(negedge clock);
            if (resetn && finished && !finished_prev) begin
                for (int a = 0; a < MEM_WORDS; a++) begin
                    check_word($sformatf("%s mem[%02h]", test_name, a), exp_mem[a],
                               dp_model_inst.mem[a]);
                end
                n = dp_model_inst.draw_log.size() - draw_seen;
                check_count(test_name, exp_draw.size(), n);
                for (int i = 0; i < exp_draw.size() && i < n; i++) begin
                    check_instr($sformatf("%s pixel %0d", test_name, i), exp_draw[i],
                                dp_model_inst.draw_log[draw_seen + i]);
                end
                draw_seen = dp_model_inst.draw_log.size();
                exp_draw.delete();
                jobs_checked++;
            end
            finished_prev = finished;
        end
    end

    initial begin : watchdog
        int cycles;
        cycles = 0;
        while (cycles < TIMEOUT_CYCLES) begin
            @(posedge clock);
            cycles++;
        end
        $display("Timeout: the jobs did not complete within %0d cycles", TIMEOUT_CYCLES);
        $display("Jobs: %0d, checks: %0d, errors: %0d", jobs_checked, checks, errors);
        $display("Testbench failed");
        $finish;
    end

    initial begin : stimulus
        ant_pkg::word_t fill;
        resetn       = 1'b0;
        start        = 1'b0;
        job          = '0;
        jobs_issued  = 0;
        jobs_checked = 0;
        draw_seen    = 0;
        checks       = 0;
        errors       = 0;
        void'($urandom(32'h1832_028e));
        for (int a = 0; a < MEM_WORDS; a++) begin
            fill = ant_pkg::word_t'((a * 16'h0101) ^ 16'hc300);
            exp_mem[a] = fill;
            dp_model_inst.mem[a] = fill;
        end
        repeat (5) @(posedge clock);
        #1;
        resetn = 1'b1;
        @(negedge clock);
        checks++;
        if (finished !== 1'b1) begin
            errors++;
            $display("ERROR after_reset finished: expected 1, actual %b", finished);
        end
        checks++;
        if (start_dp !== 1'b0) begin
            errors++;
            $display("ERROR after_reset start_dp: expected 0, actual %b", start_dp);
        end

        // Random moves on ants inside the margins
        for (int i = 0; i < 8; i++) begin
            place_ant(i, $urandom_range(X_MAX, X_MIN), $urandom_range(Y_MAX, Y_MIN));
            launch_job($sformatf("random_update_%0d", i),
                       make_job(i, ant_pkg::MODE_UPDATE, 4'($urandom)));
            wait_job_checked();
        end

        // Outward moves at the margins, then left and right together
        place_ant(10, X_MIN, Y_MIN);
        launch_job("margin_left_up", make_job(10, ant_pkg::MODE_UPDATE, 4'b1010));
        wait_job_checked();
        place_ant(11, X_MAX, Y_MAX);
        launch_job("margin_right_down", make_job(11, ant_pkg::MODE_UPDATE, 4'b0101));
        wait_job_checked();
        place_ant(12, 80, 60);
        launch_job("left_and_right", make_job(12, ant_pkg::MODE_UPDATE, 4'b1100));
        wait_job_checked();

        place_ant(20, $urandom_range(X_MAX, X_MIN), $urandom_range(Y_MAX, Y_MIN));
        launch_job("draw_random", make_job(20, ant_pkg::MODE_DRAW, 4'b0000));
        wait_job_checked();
        place_ant(21, X_MIN, Y_MIN);
        launch_job("draw_corner", make_job(21, ant_pkg::MODE_DRAW, 4'b1111));
        wait_job_checked();

        // Second start lands while the first job is still running
        place_ant(30, 50, 50);
        place_ant(31, 70, 70);
        launch_job("start_while_busy", make_job(30, ant_pkg::MODE_UPDATE, 4'b0100));
        @(posedge clock);
        #1;
        start = 1'b1;
        job   = make_job(31, ant_pkg::MODE_UPDATE, 4'b0101);
        @(posedge clock);
        #1;
        start = 1'b0;
        wait_job_checked();

        place_ant(40, 30, 40);
        place_ant(41, 100, 90);
        place_ant(42, 140, 20);
        launch_job("back_to_back_40", make_job(40, ant_pkg::MODE_UPDATE, 4'b1001));
        wait_job_checked();
        launch_job("back_to_back_41", make_job(41, ant_pkg::MODE_DRAW, 4'b0000));
        wait_job_checked();
        launch_job("back_to_back_42", make_job(42, ant_pkg::MODE_UPDATE, 4'b0110));
        wait_job_checked();

        repeat (4) @(posedge clock);
        errors = errors + dp_model_inst.bad_cmds;
        $display("Jobs: %0d, checks: %0d, errors: %0d", jobs_checked, checks, errors);
        if (errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

// File: compile.f
ant_pkg.sv
ant_job_latch.sv
ant_sequencer.sv
dp_transaction.sv
ant_engine.sv
tb_dp_model.sv
tb_ant_engine.sv
